/* project.f */
hw/roce_pkg.sv
hw/rdma_flow_ctrl.sv
hw/rx_pkt_fifo.sv
hw/ack_gap_enforcer.sv
hw/rd_req_trimmer.sv
hw/roce_shell.sv
dv/tb_clk_gen.sv
dv/tb_roce_shell.sv

/* run.sh */
#!/usr/bin/env bash
# Build the RoCE shell testbench with Verilator, run it, then scan the log.
# The run counts as failed when the log is empty or holds the fail message.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -f "$LOG" &&
verilator --binary --timing --assert -j 0 \
  --top-module tb_roce_shell \
  -f project.f \
  --Mdir obj_dir -o sim_tb &&
{ ./obj_dir/sim_tb > "$LOG" 2>&1 || true; } &&
cat "$LOG" &&
test -s "$LOG" &&
! grep -q -F '*** FAILED ***' "$LOG" &&
echo "RESULT: simulation passed" ||
{ echo "RESULT: simulation failed"; exit 1; }

/* dv/tb_roce_shell.sv */
// Testbench for the RoCE shell
// Directed tests for RX pass-through, ACK gap, read request trimming,
// send-queue credits and RX back-pressure, plus a stream monitor,
// checker tasks and a watchdog

`timescale 1ns/1ps

module tb_roce_shell;

  localparam int DATA_W          = roce_pkg::DATA_W_DEF;
  localparam int KEEP_W          = DATA_W / 8;
  localparam int ACK_GAP         = roce_pkg::ACK_GAP_DEF;
  localparam int FIFO_DEPTH      = roce_pkg::FIFO_DEPTH_DEF;
  localparam int RD_REQ_BYTES    = roce_pkg::RD_REQ_BYTES_DEF;
  localparam int MAX_OUTSTANDING = roce_pkg::MAX_OUTSTANDING_DEF;
  localparam int RESET_CYCLES    = 10;
  localparam logic [31:0] SEED   = 32'ha65c_4cc1;
  // RC RDMA WRITE ONLY opcode
  localparam roce_pkg::opcode_t OP_WRITE = 8'h0A;

  // Run length budget
  localparam int MAX_PKT_BEATS   = 8;
  localparam int BP_BEATS        = 3 * FIFO_DEPTH;
  localparam int CREDIT_CYCLES   = 16;
  localparam int TOTAL_BEATS     = 3 * MAX_PKT_BEATS + 6 + 5 + CREDIT_CYCLES + BP_BEATS;
  localparam int MARGIN          = 8;
  localparam int WATCHDOG_CYCLES = MARGIN * (RESET_CYCLES + TOTAL_BEATS + 2 * ACK_GAP);

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [KEEP_W-1:0] keep_t;

  logic nclk;
  logic rst_n;

  // DUT ports
  logic sq_valid, sq_ready, req_valid, req_ready;
  roce_pkg::qpn_t sq_qpn, req_qpn, eng_ack_qpn, ack_qpn;
  roce_pkg::len_t sq_len, req_len;
  logic eng_ack_valid, eng_ack_ready, eng_ack_last;
  logic ack_valid, ack_ready, ack_last;
  logic rx_in_valid, rx_in_ready, rx_in_last;
  logic rx_out_valid, rx_out_ready, rx_out_last;
  logic tx_in_valid, tx_in_ready, tx_in_last;
  logic tx_out_valid, tx_out_ready, tx_out_last;
  data_t rx_in_data, rx_out_data, tx_in_data, tx_out_data;
  keep_t rx_in_keep, rx_out_keep, tx_in_keep, tx_out_keep;

  // Beats to send, beats expected, beats seen at an output
  data_t snd_data[$];
  keep_t snd_keep[$];
  logic  snd_last[$];
  data_t exp_data[$];
  keep_t exp_keep[$];
  logic  exp_last[$];
  data_t got_data[$];
  keep_t got_keep[$];
  logic  got_last[$];
  int    got_cyc[$];
  int    cycle = 0;

  tb_clk_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .nclk  (nclk),
    .rst_n (rst_n)
  );

  roce_shell i_dut (
    .nclk (nclk), .rst_n (rst_n),
    .sq_valid (sq_valid), .sq_ready (sq_ready), .sq_qpn (sq_qpn), .sq_len (sq_len),
    .req_valid (req_valid), .req_ready (req_ready), .req_qpn (req_qpn), .req_len (req_len),
    .eng_ack_valid (eng_ack_valid), .eng_ack_ready (eng_ack_ready),
    .eng_ack_qpn (eng_ack_qpn), .eng_ack_last (eng_ack_last),
    .ack_valid (ack_valid), .ack_ready (ack_ready), .ack_qpn (ack_qpn), .ack_last (ack_last),
    .rx_in_valid (rx_in_valid), .rx_in_ready (rx_in_ready), .rx_in_data (rx_in_data),
    .rx_in_keep (rx_in_keep), .rx_in_last (rx_in_last),
    .rx_out_valid (rx_out_valid), .rx_out_ready (rx_out_ready), .rx_out_data (rx_out_data),
    .rx_out_keep (rx_out_keep), .rx_out_last (rx_out_last),
    .tx_in_valid (tx_in_valid), .tx_in_ready (tx_in_ready), .tx_in_data (tx_in_data),
    .tx_in_keep (tx_in_keep), .tx_in_last (tx_in_last),
    .tx_out_valid (tx_out_valid), .tx_out_ready (tx_out_ready), .tx_out_data (tx_out_data),
    .tx_out_keep (tx_out_keep), .tx_out_last (tx_out_last)
  );

  //////////////////////////////
  // Cycle count and monitor
  //////////////////////////////

  always @(posedge nclk) cycle <= cycle + 1;

  // Handshakes sampled at the falling edge ahead of the transfer edge
  always @(negedge nclk) begin
    if (rst_n && rx_out_valid && rx_out_ready) begin
      got_data.push_back(rx_out_data);
      got_keep.push_back(rx_out_keep);
      got_last.push_back(rx_out_last);
      got_cyc.push_back(cycle);
    end
    if (rst_n && tx_out_valid && tx_out_ready) begin
      got_data.push_back(tx_out_data);
      got_keep.push_back(tx_out_keep);
      got_last.push_back(tx_out_last);
      got_cyc.push_back(cycle);
    end
  end

  //////////////////////////////
  // Checkers
  //////////////////////////////

  task automatic report_mismatch(input string name, input data_t exp, input data_t act);
    $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
    $display("*** FAILED ***");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("error: %s", what);
    $display("*** FAILED ***");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_val(input string name, input data_t exp, input data_t act);
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_val(name, data_t'(exp), data_t'(act));
  endtask

  // Compare monitored beats from index base on against the expected list
  task automatic check_beats(input string name, input int base);
    int n;
    n = exp_data.size();
    while (got_data.size() < base + n) @(negedge nclk);
    // A few idle cycles so that extra beats show up
    repeat (4) @(negedge nclk);
    check_val({name, " beat count"}, data_t'(n), data_t'(got_data.size() - base));
    for (int i = 0; i < n; i++) begin
      check_val($sformatf("%s beat %0d data", name, i), exp_data[i], got_data[base + i]);
      check_val($sformatf("%s beat %0d keep", name, i),
                data_t'(exp_keep[i]), data_t'(got_keep[base + i]));
      check_bit($sformatf("%s beat %0d last", name, i), exp_last[i], got_last[base + i]);
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic data_t rand_word();
    data_t w;
    for (int i = 0; i < DATA_W / 32; i++) w[i*32 +: 32] = $urandom;
    return w;
  endfunction

  // Low RD_REQ_BYTES bytes of a beat
  function automatic keep_t hdr_keep();
    keep_t m;
    for (int b = 0; b < KEEP_W; b++) m[b] = (b < RD_REQ_BYTES);
    return m;
  endfunction

  task automatic clear_queues();
    snd_data.delete();
    snd_keep.delete();
    snd_last.delete();
    exp_data.delete();
    exp_keep.delete();
    exp_last.delete();
  endtask

  // Opcode in byte 0 of the first beat and random tail keep
  task automatic add_pkt(input roce_pkg::opcode_t op, input int nbeats);
    data_t w;
    keep_t k;
    for (int i = 0; i < nbeats; i++) begin
      w = rand_word();
      if (i == 0) w[7:0] = op;
      k = {KEEP_W{1'b1}};
      if (i == nbeats - 1) k = {KEEP_W{1'b1}} >> ($urandom % KEEP_W);
      snd_data.push_back(w);
      snd_keep.push_back(k);
      snd_last.push_back(i == nbeats - 1);
    end
  endtask

  task automatic expect_as_sent();
    exp_data = snd_data;
    exp_keep = snd_keep;
    exp_last = snd_last;
  endtask

  // Push all queued beats into rx_in or tx_in
  task automatic drive_stream(input bit on_tx);
    @(posedge nclk);
    for (int i = 0; i < snd_data.size(); i++) begin
      if (on_tx) begin
        tx_in_valid <= 1'b1;
        tx_in_data  <= snd_data[i];
        tx_in_keep  <= snd_keep[i];
        tx_in_last  <= snd_last[i];
      end else begin
        rx_in_valid <= 1'b1;
        rx_in_data  <= snd_data[i];
        rx_in_keep  <= snd_keep[i];
        rx_in_last  <= snd_last[i];
      end
      do @(negedge nclk); while (!(on_tx ? tx_in_ready : rx_in_ready));
      @(posedge nclk);
    end
    if (on_tx) tx_in_valid <= 1'b0;
    else rx_in_valid <= 1'b0;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_rx_pass();
    int base;
    base = got_data.size();
    clear_queues();
    for (int p = 0; p < 3; p++) add_pkt(OP_WRITE, 1 + int'($urandom % MAX_PKT_BEATS));
    expect_as_sent();
    drive_stream(1'b0);
    check_beats("rx_pass", base);
  endtask

  // ACK of 2 beats, ACK of 1 beat, then a write
  task automatic test_ack_gap();
    int base;
    int gap;
    base = got_data.size();
    clear_queues();
    add_pkt(roce_pkg::OP_ACK, 2);
    add_pkt(roce_pkg::OP_ACK, 1);
    add_pkt(OP_WRITE, 3);
    expect_as_sent();
    drive_stream(1'b0);
    check_beats("ack_gap", base);
    gap = got_cyc[base + 2] - got_cyc[base + 1];
    assert (gap >= ACK_GAP) else report_failure($sformatf(
      "second ACK left %0d cycles after the first one, less than the gap of %0d", gap, ACK_GAP));
  endtask

  task automatic test_rd_trim();
    int base;
    base = got_data.size();
    clear_queues();
    add_pkt(roce_pkg::OP_RD_REQ, 3);
    add_pkt(OP_WRITE, 2);
    // Header beat only and then the write untouched
    exp_data.push_back(snd_data[0]);
    exp_keep.push_back(snd_keep[0] & hdr_keep());
    exp_last.push_back(1'b1);
    for (int i = 3; i < 5; i++) begin
      exp_data.push_back(snd_data[i]);
      exp_keep.push_back(snd_keep[i]);
      exp_last.push_back(snd_last[i]);
    end
    fork
      drive_stream(1'b1);
      // Sink stalls while the read request tail is swallowed
      begin
        do @(negedge nclk); while (!(tx_out_valid && tx_out_ready));
        @(posedge nclk);
        tx_out_ready <= 1'b0;
        repeat (2) begin
          @(negedge nclk);
          check_bit("rd_trim drop tx_in_ready", 1'b1, tx_in_ready);
          check_bit("rd_trim drop tx_out_valid", 1'b0, tx_out_valid);
          @(posedge nclk);
        end
        tx_out_ready <= 1'b1;
      end
    join
    check_beats("rd_trim", base);
  endtask

  task automatic test_credit();
    roce_pkg::qpn_t qpn;
    roce_pkg::len_t len;
    @(posedge nclk);
    req_ready <= 1'b1;
    ack_ready <= 1'b1;
    for (int i = 0; i <= MAX_OUTSTANDING; i++) begin
      qpn = roce_pkg::qpn_t'(32'h100 + i);
      len = roce_pkg::len_t'(64 * (i + 1));
      sq_valid <= 1'b1;
      sq_qpn   <= qpn;
      sq_len   <= len;
      @(negedge nclk);
      if (i < MAX_OUTSTANDING) begin
        check_bit("credit req_valid", 1'b1, req_valid);
        check_bit("credit sq_ready", 1'b1, sq_ready);
        check_val("credit req_qpn", data_t'(qpn), data_t'(req_qpn));
        check_val("credit req_len", data_t'(len), data_t'(req_len));
      end
      @(posedge nclk);
    end
    // Fifth request stays blocked
    repeat (3) begin
      @(negedge nclk);
      check_bit("credit blocked req_valid", 1'b0, req_valid);
      check_bit("credit blocked sq_ready", 1'b0, sq_ready);
    end
    // Ack without last
    @(posedge nclk);
    eng_ack_valid <= 1'b1;
    eng_ack_qpn   <= 24'h000100;
    eng_ack_last  <= 1'b0;
    @(negedge nclk);
    check_bit("credit ack_valid", 1'b1, ack_valid);
    check_bit("credit eng_ack_ready", 1'b1, eng_ack_ready);
    check_val("credit ack_qpn", data_t'(24'h000100), data_t'(ack_qpn));
    check_bit("credit ack_last", 1'b0, ack_last);
    @(posedge nclk);
    eng_ack_valid <= 1'b0;
    @(negedge nclk);
    check_bit("credit no return req_valid", 1'b0, req_valid);
    // Final ack returns one credit
    @(posedge nclk);
    eng_ack_valid <= 1'b1;
    eng_ack_last  <= 1'b1;
    @(negedge nclk);
    check_bit("credit last ack_valid", 1'b1, ack_valid);
    check_val("credit last ack_qpn", data_t'(24'h000100), data_t'(ack_qpn));
    check_bit("credit last ack_last", 1'b1, ack_last);
    @(posedge nclk);
    eng_ack_valid <= 1'b0;
    @(negedge nclk);
    check_bit("credit fifth req_valid", 1'b1, req_valid);
    check_bit("credit fifth sq_ready", 1'b1, sq_ready);
    check_val("credit fifth req_qpn", data_t'(24'h000104), data_t'(req_qpn));
    @(posedge nclk);
    sq_valid <= 1'b0;
  endtask

  // Sink ready about one cycle in four so that the FIFO fills up
  task automatic test_backpressure();
    int base;
    bit done;
    bit saw_full;
    base = got_data.size();
    done = 1'b0;
    saw_full = 1'b0;
    clear_queues();
    add_pkt(OP_WRITE, BP_BEATS);
    expect_as_sent();
    fork
      begin
        drive_stream(1'b0);
        while (got_data.size() < base + exp_data.size()) @(negedge nclk);
        done = 1'b1;
      end
      begin
        while (!done) begin
          @(negedge nclk);
          if (!rx_in_ready) saw_full = 1'b1;
          @(posedge nclk);
          rx_out_ready <= (($urandom % 4) == 0);
        end
      end
    join
    @(posedge nclk);
    rx_out_ready <= 1'b1;
    check_beats("backpressure", base);
    assert (saw_full) else report_failure("rx_in_ready never dropped while the FIFO was loaded");
  endtask

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////

  initial begin
    sq_valid      = 1'b0;
    sq_qpn        = '0;
    sq_len        = '0;
    req_ready     = 1'b0;
    eng_ack_valid = 1'b0;
    eng_ack_qpn   = '0;
    eng_ack_last  = 1'b0;
    ack_ready     = 1'b0;
    rx_in_valid   = 1'b0;
    rx_in_data    = '0;
    rx_in_keep    = '0;
    rx_in_last    = 1'b0;
    rx_out_ready  = 1'b1;
    tx_in_valid   = 1'b0;
    tx_in_data    = '0;
    tx_in_keep    = '0;
    tx_in_last    = 1'b0;
    tx_out_ready  = 1'b1;
    void'($urandom(SEED));
    @(posedge rst_n);
    test_rx_pass();
    test_ack_gap();
    test_rd_trim();
    test_credit();
    test_backpressure();
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge nclk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* dv/tb_clk_gen.sv */
// Testbench clock and reset generator
// Free-running nclk and an active-low reset held for a number of cycles

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic nclk,
  output logic rst_n
);

  initial begin
    nclk = 1'b0;
    forever #(PERIOD_NS / 2) nclk = ~nclk;
  end

  // Release on a rising edge, after RESET_CYCLES edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge nclk);
    rst_n <= 1'b1;
  end

endmodule

/* hw/roce_shell.sv */
// RoCE network shell top level
// Send-queue flow control, RX buffering with ACK gap enforcement,
// and TX read request trimming around an external RoCEv2 engine

`timescale 1ns/1ps

module roce_shell #(
  parameter int DATA_W          = roce_pkg::DATA_W_DEF,
  parameter int FIFO_DEPTH      = roce_pkg::FIFO_DEPTH_DEF,
  parameter int ACK_GAP         = roce_pkg::ACK_GAP_DEF,
  parameter int RD_REQ_BYTES    = roce_pkg::RD_REQ_BYTES_DEF,
  parameter int MAX_OUTSTANDING = roce_pkg::MAX_OUTSTANDING_DEF
) (
  input  logic                  nclk,
  input  logic                  rst_n,
  // User send queue
  input  logic                  sq_valid,
  output logic                  sq_ready,
  input  roce_pkg::qpn_t        sq_qpn,
  input  roce_pkg::len_t        sq_len,
  // Requests to the engine
  output logic                  req_valid,
  input  logic                  req_ready,
  output roce_pkg::qpn_t        req_qpn,
  output roce_pkg::len_t        req_len,
  // Acks from the engine
  input  logic                  eng_ack_valid,
  output logic                  eng_ack_ready,
  input  roce_pkg::qpn_t        eng_ack_qpn,
  input  logic                  eng_ack_last,
  // Acks to the user
  output logic                  ack_valid,
  input  logic                  ack_ready,
  output roce_pkg::qpn_t        ack_qpn,
  output logic                  ack_last,
  // Network RX
  input  logic                  rx_in_valid,
  output logic                  rx_in_ready,
  input  logic [DATA_W-1:0]     rx_in_data,
  input  logic [DATA_W/8-1:0]   rx_in_keep,
  input  logic                  rx_in_last,
  // RX toward the engine
  output logic                  rx_out_valid,
  input  logic                  rx_out_ready,
  output logic [DATA_W-1:0]     rx_out_data,
  output logic [DATA_W/8-1:0]   rx_out_keep,
  output logic                  rx_out_last,
  // TX from the engine
  input  logic                  tx_in_valid,
  output logic                  tx_in_ready,
  input  logic [DATA_W-1:0]     tx_in_data,
  input  logic [DATA_W/8-1:0]   tx_in_keep,
  input  logic                  tx_in_last,
  // Network TX
  output logic                  tx_out_valid,
  input  logic                  tx_out_ready,
  output logic [DATA_W-1:0]     tx_out_data,
  output logic [DATA_W/8-1:0]   tx_out_keep,
  output logic                  tx_out_last
);

  localparam int KEEP_W = DATA_W / 8;

  // FIFO to gap enforcer
  logic              fifo_valid;
  logic              fifo_ready;
  logic [DATA_W-1:0] fifo_data;
  logic [KEEP_W-1:0] fifo_keep;
  logic              fifo_last;

  //////////////////////////////
  // Send queue and acks
  //////////////////////////////

  rdma_flow_ctrl #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_flow_ctrl (
    .nclk          (nclk),
    .rst_n         (rst_n),
    .sq_valid      (sq_valid),
    .sq_ready      (sq_ready),
    .sq_qpn        (sq_qpn),
    .sq_len        (sq_len),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_qpn       (req_qpn),
    .req_len       (req_len),
    .eng_ack_valid (eng_ack_valid),
    .eng_ack_ready (eng_ack_ready),
    .eng_ack_qpn   (eng_ack_qpn),
    .eng_ack_last  (eng_ack_last),
    .ack_valid     (ack_valid),
    .ack_ready     (ack_ready),
    .ack_qpn       (ack_qpn),
    .ack_last      (ack_last)
  );

  //////////////////////////////
  // RX path
  //////////////////////////////

  // Buffer first, so the gap stall backs up into the FIFO
  rx_pkt_fifo #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_rx_fifo (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .in_valid  (rx_in_valid),
    .in_ready  (rx_in_ready),
    .in_data   (rx_in_data),
    .in_keep   (rx_in_keep),
    .in_last   (rx_in_last),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_data  (fifo_data),
    .out_keep  (fifo_keep),
    .out_last  (fifo_last)
  );

  ack_gap_enforcer #(
    .DATA_W  (DATA_W),
    .ACK_GAP (ACK_GAP)
  ) i_ack_gap (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .in_data   (fifo_data),
    .in_keep   (fifo_keep),
    .in_last   (fifo_last),
    .out_valid (rx_out_valid),
    .out_ready (rx_out_ready),
    .out_data  (rx_out_data),
    .out_keep  (rx_out_keep),
    .out_last  (rx_out_last)
  );

  //////////////////////////////
  // TX path
  //////////////////////////////

  rd_req_trimmer #(
    .DATA_W       (DATA_W),
    .RD_REQ_BYTES (RD_REQ_BYTES)
  ) i_rd_trim (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .in_valid  (tx_in_valid),
    .in_ready  (tx_in_ready),
    .in_data   (tx_in_data),
    .in_keep   (tx_in_keep),
    .in_last   (tx_in_last),
    .out_valid (tx_out_valid),
    .out_ready (tx_out_ready),
    .out_data  (tx_out_data),
    .out_keep  (tx_out_keep),
    .out_last  (tx_out_last)
  );

endmodule

/* hw/rd_req_trimmer.sv */
// Read request trimmer for the TX path
// Cuts RDMA READ REQUEST packets to their first beat, with keep
// limited to the BTH and RETH, and swallows the rest of the packet

`timescale 1ns/1ps

module rd_req_trimmer #(
  parameter int DATA_W       = 256,
  parameter int RD_REQ_BYTES = 28
) (
  input  logic                  nclk,
  input  logic                  rst_n,
  // Input stream
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [DATA_W-1:0]     in_data,
  input  logic [DATA_W/8-1:0]   in_keep,
  input  logic                  in_last,
  // Output stream
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [DATA_W-1:0]     out_data,
  output logic [DATA_W/8-1:0]   out_keep,
  output logic                  out_last
);

  localparam int KEEP_W = DATA_W / 8;
  // Low RD_REQ_BYTES bytes of a beat
  localparam logic [KEEP_W-1:0] HDR_KEEP = {KEEP_W{1'b1}} >> (KEEP_W - RD_REQ_BYTES);

  typedef enum logic [1:0] {
    ST_FIRST,
    ST_FWD,
    ST_DROP
  } state_t;

  state_t              state;
  roce_pkg::opcode_t   opcode;
  logic                is_rd_req;
  logic                trim;
  logic                xfer;

  assign opcode    = in_data[7:0];
  assign is_rd_req = (opcode == roce_pkg::OP_RD_REQ);
  // Header beat of a read request
  assign trim      = (state == ST_FIRST) & is_rd_req;

  //////////////////////////////
  // Stream path
  //////////////////////////////

  // Drop state accepts everything and shows nothing
  assign out_valid = (state == ST_DROP) ? 1'b0 : in_valid;
  assign in_ready  = (state == ST_DROP) ? 1'b1 : out_ready;
  assign out_data  = in_data;
  assign out_keep  = trim ? (in_keep & HDR_KEEP) : in_keep;
  assign out_last  = trim | in_last;
  assign xfer      = in_valid & in_ready;

  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_FIRST;
    end else if (xfer) begin
      case (state)
        ST_FIRST: begin
          // Single-beat packets stay here
          if (!in_last) state <= is_rd_req ? ST_DROP : ST_FWD;
        end
        ST_FWD:   if (in_last) state <= ST_FIRST;
        ST_DROP:  if (in_last) state <= ST_FIRST;
        default:  state <= ST_FIRST;
      endcase
    end
  end

endmodule

/* hw/ack_gap_enforcer.sv */
// ACK gap enforcer for the RX path
// Classifies packets by the opcode of their first beat and holds
// the start of an ACK until the gap after the previous ACK is over

`timescale 1ns/1ps

module ack_gap_enforcer #(
  parameter int DATA_W  = 256,
  parameter int ACK_GAP = 85
) (
  input  logic                  nclk,
  input  logic                  rst_n,
  // Input stream
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [DATA_W-1:0]     in_data,
  input  logic [DATA_W/8-1:0]   in_keep,
  input  logic                  in_last,
  // Output stream
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [DATA_W-1:0]     out_data,
  output logic [DATA_W/8-1:0]   out_keep,
  output logic                  out_last
);

  // Gap counter holds 0 .. ACK_GAP
  localparam int GAP_W = (ACK_GAP < 1) ? 1 : $clog2(ACK_GAP + 1);
  localparam logic [GAP_W-1:0] GAP_LOAD = GAP_W'(ACK_GAP);

  // Position inside the current packet
  typedef enum logic {
    ST_FIRST,
    ST_PKT
  } state_t;

  state_t              state;
  roce_pkg::opcode_t   opcode;
  logic                is_ack;
  logic                pkt_is_ack;
  logic                cur_ack;
  logic [GAP_W-1:0]    gap_cnt;
  logic                hold;
  logic                xfer;

  // BTH starts at byte 0
  assign opcode = in_data[7:0];
  assign is_ack = (opcode == roce_pkg::OP_ACK);

  // ACK flag of the beat on the bus
  assign cur_ack = (state == ST_FIRST) ? is_ack : pkt_is_ack;

  // Stall only the first beat of an ACK while the gap runs
  assign hold = (state == ST_FIRST) & is_ack & (gap_cnt != '0);

  //////////////////////////////
  // Stream path
  //////////////////////////////

  assign out_valid = in_valid & ~hold;
  assign in_ready  = out_ready & ~hold;
  assign out_data  = in_data;
  assign out_keep  = in_keep;
  assign out_last  = in_last;
  assign xfer      = in_valid & in_ready;

  // Packet tracking
  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_FIRST;
      pkt_is_ack <= 1'b0;
    end else if (xfer) begin
      if (state == ST_FIRST) begin
        pkt_is_ack <= is_ack;
        if (!in_last) state <= ST_PKT;
      end else if (in_last) begin
        state <= ST_FIRST;
      end
    end
  end

  // Gap counter reloaded by the last beat of every ACK
  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      gap_cnt <= '0;
    end else if (xfer && in_last && cur_ack) begin
      gap_cnt <= GAP_LOAD;
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

endmodule

/* hw/rx_pkt_fifo.sv */
// RX packet buffer
// Circular stream FIFO holding data, keep and last per beat,
// full-rate on both sides with a registered occupancy count

`timescale 1ns/1ps

module rx_pkt_fifo #(
  parameter int DATA_W     = 256,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                  nclk,
  input  logic                  rst_n,
  // Input stream
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [DATA_W-1:0]     in_data,
  input  logic [DATA_W/8-1:0]   in_keep,
  input  logic                  in_last,
  // Output stream
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [DATA_W-1:0]     out_data,
  output logic [DATA_W/8-1:0]   out_keep,
  output logic                  out_last
);

  localparam int KEEP_W = DATA_W / 8;
  // Pointer and count widths
  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);
  localparam logic [AW-1:0] PTR_LAST = AW'(FIFO_DEPTH - 1);
  localparam logic [CW-1:0] CNT_FULL = CW'(FIFO_DEPTH);

  // Beat storage
  logic [DATA_W-1:0] mem_data [FIFO_DEPTH];
  logic [KEEP_W-1:0] mem_keep [FIFO_DEPTH];
  logic              mem_last [FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          wr_en;
  logic          rd_en;

  assign in_ready  = (count != CNT_FULL);
  assign out_valid = (count != '0);
  assign wr_en     = in_valid & in_ready;
  assign rd_en     = out_valid & out_ready;

  // Head of queue straight from storage
  assign out_data = mem_data[rd_ptr];
  assign out_keep = mem_keep[rd_ptr];
  assign out_last = mem_last[rd_ptr];

  always_ff @(posedge nclk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= in_data;
      mem_keep[wr_ptr] <= in_keep;
      mem_last[wr_ptr] <= in_last;
    end
  end

  // Pointers wrap at depth, not at a power of two
  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      // Occupancy
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hw/rdma_flow_ctrl.sv */
// Send-queue flow control
// Credit counter limiting requests in flight toward the engine,
// forwarding of engine acks and credit return on the last ack

`timescale 1ns/1ps

module rdma_flow_ctrl #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic             nclk,
  input  logic             rst_n,
  // User send queue
  input  logic             sq_valid,
  output logic             sq_ready,
  input  roce_pkg::qpn_t   sq_qpn,
  input  roce_pkg::len_t   sq_len,
  // Requests toward the engine
  output logic             req_valid,
  input  logic             req_ready,
  output roce_pkg::qpn_t   req_qpn,
  output roce_pkg::len_t   req_len,
  // Acks from the engine
  input  logic             eng_ack_valid,
  output logic             eng_ack_ready,
  input  roce_pkg::qpn_t   eng_ack_qpn,
  input  logic             eng_ack_last,
  // Acks toward the user
  output logic             ack_valid,
  input  logic             ack_ready,
  output roce_pkg::qpn_t   ack_qpn,
  output logic             ack_last
);

  // Counter must hold 0 .. MAX_OUTSTANDING
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MAX_OUTSTANDING);

  logic [CNT_W-1:0] cnt;
  logic             credit_avail;
  logic             req_xfer;
  logic             ack_ret;

  // Room for one more request
  assign credit_avail = (cnt < CNT_MAX);

  //////////////////////////////
  // Request channel
  //////////////////////////////

  // Both sides of the handshake gated by the credit
  assign req_valid = sq_valid & credit_avail;
  assign sq_ready  = req_ready & credit_avail;
  assign req_qpn   = sq_qpn;
  assign req_len   = sq_len;

  //////////////////////////////
  // Ack channel
  //////////////////////////////

  assign ack_valid     = eng_ack_valid;
  assign eng_ack_ready = ack_ready;
  assign ack_qpn       = eng_ack_qpn;
  assign ack_last      = eng_ack_last;

  assign req_xfer = req_valid & req_ready;
  // Only the final ack of a request returns its credit
  assign ack_ret  = ack_valid & ack_ready & ack_last;

  // Outstanding count
  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      case ({req_xfer, ack_ret})
        2'b10: cnt <= cnt + 1'b1;
        // Saturate at zero on a stray ack
        2'b01: if (cnt != '0) cnt <= cnt - 1'b1;
        // Simultaneous, only a stray ack changes the net count
        2'b11: if (cnt == '0) cnt <= cnt + 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

endmodule

/* hw/roce_pkg.sv */
// RoCE shell shared definitions
// Field types for queue pair and transfer metadata, BTH opcodes
// and the default values of the shell parameters

package roce_pkg;

  //////////////////////////////
  // Field types
  //////////////////////////////

  // BTH opcode, byte 0 of the header
  typedef logic [7:0]  opcode_t;
  // Queue pair number, 24 bits as in the BTH
  typedef logic [23:0] qpn_t;
  // Transfer length in bytes
  typedef logic [31:0] len_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // RC acknowledge
  localparam opcode_t OP_ACK    = 8'h11;
  // RC RDMA read request
  localparam opcode_t OP_RD_REQ = 8'h0C;

  //////////////////////////////
  // Default parameters
  //////////////////////////////

  // Network stream width in bits
  localparam int DATA_W_DEF          = 256;
  // BTH (12 bytes) plus RETH (16 bytes)
  localparam int RD_REQ_BYTES_DEF    = 28;
  // Idle cycles kept between two ACKs on RX
  localparam int ACK_GAP_DEF         = 85;
  // RX buffer depth in beats
  localparam int FIFO_DEPTH_DEF      = 16;
  // Send-queue requests in flight
  localparam int MAX_OUTSTANDING_DEF = 4;

endpackage
